/* rtl/fifoPkg.sv */
// dual clock fifo shared definitions
package fifoPkg;

	// --------------------------------------------------
	// sizing helpers
	// --------------------------------------------------

	// position of the highest set bit
	function automatic int fHighBit(input int value);
		int pos;
		pos = 0;
		for (int i = 0; i < 32; i++)
		begin
			if (value[i])
				pos = i;
		end
		return pos;
	endfunction

	// block ram lane width for a given depth
	// deeper ram means narrower lane
	function automatic int fLaneWidth(input int depth);
		int width;
		if (depth <= 256)
			width = 16;
		else if (depth <= 512)
			width = 8;
		else if (depth <= 1024)
			width = 4;
		else if (depth <= 2048)
			width = 2;
		else
			width = 1;
		return width;
	endfunction

	// --------------------------------------------------
	// sizing
	// --------------------------------------------------
	localparam int cFifoDepth  = 512;
	localparam int cDataWidth  = 16;
	// no extra wrap bit, one word is always kept free
	localparam int cAddrWidth  = fHighBit(cFifoDepth);
	localparam int cLaneWidth  = fLaneWidth(cFifoDepth);
	// lanes side by side, rounded up
	localparam int cLaneCount  = (cDataWidth + cLaneWidth - 1) / cLaneWidth;
	localparam int cAlertLevel = cFifoDepth / 2;

	// --------------------------------------------------
	// types
	// --------------------------------------------------
	// binary and gray pointers share this
	typedef logic [cAddrWidth-1:0] tAddr;
	typedef logic [cDataWidth-1:0] tData;
	// slice held by one ram lane
	typedef logic [cLaneWidth-1:0] tLane;

	// one ram write, all lanes see the same enable and address
	typedef struct packed
	{
		logic en;
		tAddr addr;
		tData data;
	} tRamWr;

endpackage

/* rtl/grayPtrSync.sv */
// gray coded pointer crossing
module grayPtrSync
(
	input  logic          inARST,
	input  logic          iSrcClk,
	input  logic          iDstClk,
	input  logic          iInc,
	output fifoPkg::tAddr oBin,
	output fifoPkg::tAddr oSyncBin
);
	import fifoPkg::*;

	// --------------------------------------------------
	// source domain
	// --------------------------------------------------

	// binary address pointer
	tAddr rBin;
	// gray copy, the only value that crosses
	tAddr rGray;

	// --------------------------------------------------
	// destination domain
	// --------------------------------------------------

	// first stage, may go metastable
	tAddr rSyncMeta;
	// second stage, settled gray value
	tAddr rSyncStable;
	// decoded binary pointer
	tAddr qDecode;

	// --------------------------------------------------
	// pointer and gray encode
	// --------------------------------------------------
	always_ff @(posedge iSrcClk or negedge inARST)
	begin
		if (!inARST)
		begin
			rBin  <= '0;
			rGray <= '0;
		end
		else
		begin
			// wraps at depth, no extra bit
			if (iInc)
				rBin <= rBin + 1'b1;
			// gray lags binary by one clock
			// pointer moves by one at most, so one gray bit flips
			rGray <= rBin ^ (rBin >> 1);
		end
	end

	// --------------------------------------------------
	// two flop synchronizer
	// --------------------------------------------------
	always_ff @(posedge iDstClk or negedge inARST)
	begin
		if (!inARST)
		begin
			rSyncMeta   <= '0;
			rSyncStable <= '0;
		end
		else
		begin
			rSyncMeta   <= rGray;
			rSyncStable <= rSyncMeta;
		end
	end

	// --------------------------------------------------
	// gray to binary decode
	// --------------------------------------------------
	always_comb
	begin
		// msb passes straight through
		qDecode[cAddrWidth-1] = rSyncStable[cAddrWidth-1];
		// each lower bit folds in the bit above it
		for (int i = cAddrWidth - 2; i >= 0; i--)
		begin
			qDecode[i] = rSyncStable[i] ^ qDecode[i+1];
		end
	end

	// source domain view
	assign oBin = rBin;
	// destination domain view, lags by the sync stages
	assign oSyncBin = qDecode;

endmodule

/* rtl/sdpBram.sv */
// simple dual port ram lane
module sdpBram
(
	input  logic          iWCLK,
	input  logic          iRCLK,
	input  logic          iWe,
	input  fifoPkg::tAddr iWa,
	input  fifoPkg::tLane iWd,
	input  logic          iRe,
	input  fifoPkg::tAddr iRa,
	output fifoPkg::tLane oRd
);
	import fifoPkg::*;

	// --------------------------------------------------
	// storage
	// --------------------------------------------------

	// one lane slice per word
	tLane rMem [cFifoDepth];
	// read output register
	tLane rRd;

	// --------------------------------------------------
	// write port
	// --------------------------------------------------

	// write domain, gated enable from controller
	always_ff @(posedge iWCLK)
	begin
		if (iWe)
			rMem[iWa] <= iWd;
	end

	// --------------------------------------------------
	// read port
	// --------------------------------------------------

	// read domain, loads only on an accepted read
	// rejected read keeps the last word on the output
	always_ff @(posedge iRCLK)
	begin
		if (iRe)
			rRd <= rMem[iRa];
	end

	// data valid one read clock after iRe
	assign oRd = rRd;

endmodule

/* rtl/asyncFifoController.sv */
// dual clock fifo controller
module asyncFifoController
(
	input  fifoPkg::tData iWd,
	input  logic          iWe,
	output logic          oFull,
	output logic          oRemaingCntAlert,
	output fifoPkg::tData oRd,
	input  logic          iRe,
	output logic          oRvd,
	output logic          oEmp,
	input  logic          inARST,
	input  logic          iWCLK,
	input  logic          iRCLK
);
	import fifoPkg::*;

	// --------------------------------------------------
	// signals
	// --------------------------------------------------

	// write pointer, write domain
	tAddr wWrBin;
	// write pointer seen from read domain
	tAddr wWrSyncBin;
	// read pointer, read domain
	tAddr wRdBin;
	// read pointer seen from write domain
	tAddr wRdSyncBin;

	// next write address, for full check
	tAddr qWrNext;
	// words in flight as seen by the writer
	tAddr qWrFill;

	// flags
	logic qFull;
	logic qEmp;
	logic qAlert;

	// gated strobes
	logic qWe;
	logic qRe;

	// ram write bundle
	tRamWr sRamWr;

	// lane packed write and read words
	// padded up to a whole number of lanes
	logic [cLaneCount*cLaneWidth-1:0] qWdLanes;
	logic [cLaneCount*cLaneWidth-1:0] wRdLanes;

	// read valid register
	logic rRvd;

	// --------------------------------------------------
	// pointer crossings
	// --------------------------------------------------

	// write side pointer into the read domain
	grayPtrSync uWrPtr
	(
		.inARST   (inARST),
		.iSrcClk  (iWCLK),
		.iDstClk  (iRCLK),
		.iInc     (qWe),
		.oBin     (wWrBin),
		.oSyncBin (wWrSyncBin)
	);

	// read side pointer into the write domain
	grayPtrSync uRdPtr
	(
		.inARST   (inARST),
		.iSrcClk  (iRCLK),
		.iDstClk  (iWCLK),
		.iInc     (qRe),
		.oBin     (wRdBin),
		.oSyncBin (wRdSyncBin)
	);

	// --------------------------------------------------
	// flags and strobe gating
	// --------------------------------------------------
	always_comb
	begin
		// write domain, modulo depth by width
		qWrNext = wWrBin + 1'b1;
		qWrFill = wWrBin - wRdSyncBin;

		// full one word early, depth minus one capacity
		qFull  = (qWrNext == wRdSyncBin);
		// alert on occupancy at or above the level
		qAlert = (qWrFill >= tAddr'(cAlertLevel));

		// read domain
		// stale write pointer only delays the fall of empty
		qEmp = (wWrSyncBin == wRdBin);

		// drop writes when full, ignore reads when empty
		qWe = iWe & ~qFull;
		qRe = iRe & ~qEmp;
	end

	assign oFull            = qFull;
	assign oEmp             = qEmp;
	assign oRemaingCntAlert = qAlert;

	// --------------------------------------------------
	// ram write and lane split
	// --------------------------------------------------
	always_comb
	begin
		sRamWr.en   = qWe;
		sRamWr.addr = wWrBin;
		sRamWr.data = iWd;

		// unused upper lane bits stay zero
		qWdLanes                 = '0;
		qWdLanes[cDataWidth-1:0] = sRamWr.data;
	end

	// lanes share address and strobes
	for (genvar gLane = 0; gLane < cLaneCount; gLane++)
	begin : genLane
		sdpBram uLane
		(
			.iWCLK (iWCLK),
			.iRCLK (iRCLK),
			.iWe   (sRamWr.en),
			.iWa   (sRamWr.addr),
			.iWd   (qWdLanes[gLane*cLaneWidth +: cLaneWidth]),
			.iRe   (qRe),
			.iRa   (wRdBin),
			.oRd   (wRdLanes[gLane*cLaneWidth +: cLaneWidth])
		);
	end

	// lanes joined back into one word
	assign oRd = wRdLanes[cDataWidth-1:0];

	// --------------------------------------------------
	// read valid
	// --------------------------------------------------

	// one pulse per accepted read, same cycle as lane output
	always_ff @(posedge iRCLK or negedge inARST)
	begin
		if (!inARST)
			rRvd <= 1'b0;
		else
			rRvd <= qRe;
	end

	assign oRvd = rRvd;

endmodule

/* bench/asyncFifo_properties.sv */
// fifo controller assertions
module asyncFifoProperties
(
	input logic           iWCLK,
	input logic           iRCLK,
	input logic           inARST,
	input logic           full,
	input logic           empty,
	input logic           readValid,
	input fifoPkg::tAddr  wrBin,
	input fifoPkg::tAddr  rdBin,
	input fifoPkg::tAddr  wrGray,
	input fifoPkg::tAddr  rdGray
);
	timeunit 1ns;
	timeprecision 100ps;

	// failures seen so far, read by the testbench
	int assertFails = 0;

	// --------------------------------------------------
	// strobe gating
	// --------------------------------------------------

	// write pointer holds after a cycle that saw full
	noWriteWhenFull : assert property (@(posedge iWCLK) disable iff (!inARST)
		full |=> $stable(wrBin))
	else
	begin
		$error("ram write taken while full");
		assertFails++;
	end

	// empty in one cycle, no valid and no pointer move in the next
	noValidAfterEmpty : assert property (@(posedge iRCLK) disable iff (!inARST)
		empty |=> !readValid && $stable(rdBin))
	else
	begin
		$error("read valid after an empty cycle");
		assertFails++;
	end

	// --------------------------------------------------
	// gray pointers
	// --------------------------------------------------
	wrGrayOneBit : assert property (@(posedge iWCLK) disable iff (!inARST)
		$onehot0(wrGray ^ $past(wrGray)))
	else
	begin
		$error("write gray pointer moved more than one bit");
		assertFails++;
	end

	rdGrayOneBit : assert property (@(posedge iRCLK) disable iff (!inARST)
		$onehot0(rdGray ^ $past(rdGray)))
	else
	begin
		$error("read gray pointer moved more than one bit");
		assertFails++;
	end

endmodule

bind asyncFifoController asyncFifoProperties uProps
(
	.iWCLK     (iWCLK),
	.iRCLK     (iRCLK),
	.inARST    (inARST),
	.full      (oFull),
	.empty     (oEmp),
	.readValid (oRvd),
	.wrBin     (wWrBin),
	.rdBin     (wRdBin),
	.wrGray    (uWrPtr.rGray),
	.rdGray    (uRdPtr.rGray)
);

/* bench/asyncFifoTb.sv */
// dual clock fifo testbench
module asyncFifoTb;
	timeunit 1ns;
	timeprecision 100ps;

	import fifoPkg::*;

	// --------------------------------------------------
	// run constants
	// --------------------------------------------------
	localparam int cRPeriod         = 4;
	localparam int cWPeriod         = 6;
	localparam int unsigned cSeed   = 32'h4b7d8386;
	// depth minus one, no wrap bit in the pointers
	localparam int cCapacity        = cFifoDepth - 1;
	localparam int cRandWords       = 2000;
	localparam int cDropWrites      = 20;
	localparam int cEmptyReads      = 40;
	localparam int cAlertSmall      = 255;
	localparam int cAlertExact      = 256;
	localparam int cAlertLarge      = 300;
	localparam int cAlertWords      = cAlertSmall + cAlertExact + cAlertLarge;
	localparam int cResetWords      = 100;
	localparam int cAfterResetWords = 500;
	localparam int cDrainCycles     = 50;
	localparam int cTotalWrites     = cRandWords + cCapacity + cDropWrites + cAlertWords
		+ cResetWords + cAfterResetWords;
	localparam int cTotalReads      = cRandWords + cCapacity + cEmptyReads + cAlertWords
		+ cAfterResetWords;
	// slower clock per word, x4 for random strobes and margin
	localparam int cWatchdogNs      = (cTotalWrites + cTotalReads) * cWPeriod * 4 + 20000;

	// --------------------------------------------------
	// dut signals
	// --------------------------------------------------
	tData iWd;
	logic iWe;
	logic oFull;
	logic oRemaingCntAlert;
	tData oRd;
	logic iRe;
	logic oRvd;
	logic oEmp;
	logic inARST;
	logic iWCLK = 1'b0;
	logic iRCLK = 1'b0;

	// reference model state
	tData modelQueue[$];
	int pushCount;
	int rvdCount;
	int checkedWords;
	int valueErrors;
	int otherErrors;
	int alertSizes[3] = '{cAlertSmall, cAlertExact, cAlertLarge};

	asyncFifoController u_asyncFifoController
	(
		.iWd              (iWd),
		.iWe              (iWe),
		.oFull            (oFull),
		.oRemaingCntAlert (oRemaingCntAlert),
		.oRd              (oRd),
		.iRe              (iRe),
		.oRvd             (oRvd),
		.oEmp             (oEmp),
		.inARST           (inARST),
		.iWCLK            (iWCLK),
		.iRCLK            (iRCLK)
	);

	// --------------------------------------------------
	// clocks
	// --------------------------------------------------
	initial
	begin
		forever #(cRPeriod / 2) iRCLK = ~iRCLK;
	end

	initial
	begin
		forever #(cWPeriod / 2) iWCLK = ~iWCLK;
	end

	// --------------------------------------------------
	// reporting helpers
	// --------------------------------------------------
	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		valueErrors++;
		$display("[ERROR] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
	endtask

	task automatic reportProblem(input string what);
		otherErrors++;
		$display("problem at t=%0t: %s", $time, what);
	endtask

	// expected next word, oldest accepted write first
	function automatic tData popExpected();
		return modelQueue.pop_front();
	endfunction

	// --------------------------------------------------
	// write monitor and read compare
	// --------------------------------------------------

	// sampled mid low phase, commits on the next rising edge
	always
	begin
		@(negedge iWCLK);
		#(cWPeriod / 4.0);
		if (inARST === 1'b1 && iWe === 1'b1 && oFull === 1'b0)
		begin
			modelQueue.push_back(iWd);
			pushCount++;
		end
	end

	// oRvd and oRd settle after the rising edge, so check on the falling one
	always @(negedge iRCLK)
	begin
		tData expected;
		if (oRvd === 1'b1)
		begin
			rvdCount++;
			if (modelQueue.size() == 0)
				reportProblem("read valid pulse with no word left in the model");
			else
			begin
				checkedWords++;
				expected = popExpected();
				if (oRd !== expected)
					reportMismatch("oRd", expected, oRd);
			end
		end
	end

	// --------------------------------------------------
	// stimulus tasks
	// --------------------------------------------------

	// count writes taken; oFull only moves on a rising edge
	task automatic writeWords(input int count, input int pct);
		int sent;
		sent = 0;
		while (sent < count)
		begin
			@(negedge iWCLK);
			iWe = (($urandom % 100) < pct);
			iWd = tData'($urandom);
			if (iWe && !oFull)
				sent++;
		end
		@(negedge iWCLK);
		iWe = 1'b0;
	endtask

	// same on the read side, oEmp only moves on a rising iRCLK
	task automatic readWords(input int count, input int pct);
		int got;
		got = 0;
		while (got < count)
		begin
			@(negedge iRCLK);
			iRe = (($urandom % 100) < pct);
			if (iRe && !oEmp)
				got++;
		end
		@(negedge iRCLK);
		iRe = 1'b0;
	endtask

	// wait for the last read valid, then the model must be empty
	task automatic waitReadValids(input int target, input string phase);
		int cycles;
		cycles = 0;
		@(posedge iRCLK);
		while (rvdCount != target && cycles < cDrainCycles)
		begin
			@(posedge iRCLK);
			cycles++;
		end
		if (rvdCount != target)
			reportProblem($sformatf("%s: read valid pulses stopped short", phase));
		if (modelQueue.size() != 0)
			reportProblem($sformatf("%s: words left in the model after drain", phase));
		if (rvdCount != pushCount)
			reportMismatch("oRvd pulse count", pushCount, rvdCount);
	endtask

	task automatic checkResetFlags();
		if (oEmp !== 1'b1)
			reportMismatch("oEmp", 1, oEmp);
		if (oFull !== 1'b0)
			reportMismatch("oFull", 0, oFull);
		if (oRvd !== 1'b0)
			reportMismatch("oRvd", 0, oRvd);
		if (oRemaingCntAlert !== 1'b0)
			reportMismatch("oRemaingCntAlert", 0, oRemaingCntAlert);
	endtask

	// two iRCLK cycles low, model cleared with the dut
	task automatic applyReset();
		inARST = 1'b0;
		modelQueue.delete();
		pushCount = 0;
		rvdCount  = 0;
		@(negedge iRCLK);
		checkResetFlags();
		@(negedge iRCLK);
		inARST = 1'b1;
		@(negedge iRCLK);
		checkResetFlags();
	endtask

	// --------------------------------------------------
	// watchdog
	// --------------------------------------------------
	initial
	begin
		#(cWatchdogNs);
		$display("timeout: run still busy after %0d ns", cWatchdogNs);
		$display("Regression failed");
		$finish;
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial
	begin
		int accepted;
		int n;
		int assertErrors;
		void'($urandom(cSeed));
		iWd          = '0;
		iWe          = 1'b0;
		iRe          = 1'b0;
		inARST       = 1'b0;
		pushCount    = 0;
		rvdCount     = 0;
		checkedWords = 0;
		valueErrors  = 0;
		otherErrors  = 0;

		// reset state
		applyReset();

		// ordering across clocks, random strobes
		fork
			writeWords(cRandWords, 50);
			readWords(cRandWords, 50);
		join
		waitReadValids(cRandWords, "random traffic");
		repeat (10) @(negedge iWCLK);

		// fill to full with reads held off
		accepted = 0;
		n = 0;
		while (n == 0)
		begin
			@(negedge iWCLK);
			if (oFull === 1'b1 || accepted > cCapacity)
				n = 1;
			else
			begin
				iWe = 1'b1;
				iWd = tData'($urandom);
				accepted++;
			end
		end
		if (accepted != cCapacity)
			reportMismatch("accepted writes at oFull", cCapacity, accepted);
		// writes while full are dropped
		repeat (cDropWrites)
		begin
			@(negedge iWCLK);
			iWe = 1'b1;
			iWd = tData'($urandom);
			if (oFull !== 1'b1)
				reportMismatch("oFull", 1, oFull);
		end
		@(negedge iWCLK);
		iWe = 1'b0;
		readWords(cCapacity, 100);
		waitReadValids(cCapacity + cRandWords, "full readback");
		repeat (10) @(negedge iWCLK);

		// reads on an empty fifo are ignored
		repeat (cEmptyReads)
		begin
			@(negedge iRCLK);
			iRe = 1'b1;
			if (oEmp !== 1'b1)
				reportMismatch("oEmp", 1, oEmp);
			if (oRvd !== 1'b0)
				reportMismatch("oRvd", 0, oRvd);
		end
		@(negedge iRCLK);
		iRe = 1'b0;

		// alert level around half depth
		foreach (alertSizes[i])
		begin
			n = alertSizes[i];
			writeWords(n, 100);
			repeat (10) @(negedge iWCLK);
			if (oRemaingCntAlert !== (n >= cAlertLevel))
				reportMismatch("oRemaingCntAlert", n >= cAlertLevel, oRemaingCntAlert);
			readWords(n, 100);
			waitReadValids(pushCount, "alert drain");
			repeat (10) @(negedge iWCLK);
			if (oRemaingCntAlert !== 1'b0)
				reportMismatch("oRemaingCntAlert", 0, oRemaingCntAlert);
		end

		// reset with data still buffered
		writeWords(cResetWords, 100);
		repeat (4) @(negedge iRCLK);
		applyReset();
		fork
			writeWords(cAfterResetWords, 70);
			readWords(cAfterResetWords, 70);
		join
		waitReadValids(cAfterResetWords, "traffic after reset");
		repeat (4) @(negedge iRCLK);

		assertErrors = u_asyncFifoController.uProps.assertFails;
		$display("summary: %0d value errors, %0d other errors, %0d assertion errors, %0d words",
			valueErrors, otherErrors, assertErrors, checkedWords);
		if (valueErrors + otherErrors + assertErrors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* all.f */
rtl/fifoPkg.sv
rtl/grayPtrSync.sv
rtl/sdpBram.sv
rtl/asyncFifoController.sv
bench/asyncFifo_properties.sv
bench/asyncFifoTb.sv
